// File: sources.f
src/npc_pkg.sv
src/axi_bus_if.sv
src/ifu_fetch.sv
src/lsu_access.sv
src/axi_arbiter.sv
src/axi_sram.sv
src/npc_mem_top.sv
tb/npc_mem_tb.sv

// File: tb/npc_mem_tb.sv
`default_nettype none
`timescale 1ns/1ps

module npc_mem_tb import npc_pkg::*; ();

	// cycles any single wait may take
	localparam int TIMEOUT = 60;

	logic              clk;
	logic              rst;
	logic              fetch_valid;
	logic              fetch_ready;
	logic [ADDR_W-1:0] fetch_pc;
	logic              inst_valid;
	logic              inst_ready;
	logic [INST_W-1:0] inst;
	logic              inst_err;
	logic              req_valid;
	logic              req_ready;
	logic              req_write;
	mem_size_e         req_size;
	logic              req_unsigned;
	logic [ADDR_W-1:0] req_addr;
	logic [DATA_W-1:0] req_wdata;
	logic              rsp_valid;
	logic              rsp_ready;
	logic [DATA_W-1:0] rsp_rdata;
	logic              rsp_err;

	int err_cnt;
	int n_tests;
	int n_failed;

	// byte-wide model of the sram contents
	logic [7:0] mem_model [logic [31:0]];

	npc_mem_top dut_i (
		.clk          (clk),
		.rst          (rst),
		.fetch_valid  (fetch_valid),
		.fetch_ready  (fetch_ready),
		.fetch_pc     (fetch_pc),
		.inst_valid   (inst_valid),
		.inst_ready   (inst_ready),
		.inst         (inst),
		.inst_err     (inst_err),
		.req_valid    (req_valid),
		.req_ready    (req_ready),
		.req_write    (req_write),
		.req_size     (req_size),
		.req_unsigned (req_unsigned),
		.req_addr     (req_addr),
		.req_wdata    (req_wdata),
		.rsp_valid    (rsp_valid),
		.rsp_ready    (rsp_ready),
		.rsp_rdata    (rsp_rdata),
		.rsp_err      (rsp_err)
	);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ****************************************
	// held responses must not move
	// ****************************************
	assert property (@(posedge clk) disable iff (rst)
		(inst_valid && !inst_ready) |=> (inst_valid && $stable(inst) && $stable(inst_err)))
	else begin
		$display("fetch response dropped or changed while inst_ready was low, at %0t", $time);
		err_cnt++;
	end

	assert property (@(posedge clk) disable iff (rst)
		(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata) && $stable(rsp_err)))
	else begin
		$display("load/store response dropped or changed while rsp_ready was low, at %0t", $time);
		err_cnt++;
	end

	// ****************************************
	// checking and bookkeeping
	// ****************************************
	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
		assert (got === exp)
		else begin
			$display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	task automatic timed_out(input string what);
		$display("timeout at %0t: %s did not rise within %0d cycles", $time, what, TIMEOUT);
		err_cnt++;
	endtask

	task automatic close_test(input string name, input int mark);
		n_tests++;
		if (err_cnt == mark) begin
			$display("test %0d %s: passed", n_tests, name);
		end else begin
			n_failed++;
			$display("test %0d %s: failed with %0d errors", n_tests, name, err_cnt - mark);
		end
	endtask

	// ****************************************
	// reference model
	// ****************************************
	// low size-many bytes of the data land at addr upward
	function automatic void store_model(logic [31:0] addr, mem_size_e size, logic [63:0] data);
		for (int i = 0; i < (1 << int'(size)); i++)
			mem_model[addr + i] = data[8*i +: 8];
	endfunction

	function automatic logic [63:0] load_model(logic [31:0] addr, mem_size_e size, logic uns);
		logic [63:0] v;
		int          n;
		n = 1 << int'(size);
		v = '0;
		for (int i = 0; i < n; i++)
			v[8*i +: 8] = mem_model[addr + i];
		// sign fill above the top loaded byte
		if (!uns && n < 8 && v[8*n-1])
			v = v | (~64'd0 << (8*n));
		return v;
	endfunction

	// little endian word at pc
	function automatic logic [31:0] inst_model(logic [31:0] pc);
		logic [31:0] v;
		for (int i = 0; i < 4; i++)
			v[8*i +: 8] = mem_model[pc + i];
		return v;
	endfunction

	// random sram address aligned to the access size
	function automatic logic [31:0] rand_addr(mem_size_e size);
		logic [31:0] off;
		off = $urandom % SRAM_BYTES;
		return SRAM_BASE + (off & ~((32'd1 << size) - 1));
	endfunction

	// ****************************************
	// client port drivers
	// ****************************************
	task automatic lsu_request(input logic write, input mem_size_e size, input logic uns,
			input logic [31:0] addr, input logic [63:0] wdata,
			output logic [63:0] rdata, output logic err);
		int cnt;
		int hold;
		@(negedge clk);
		req_valid    = 1'b1;
		req_write    = write;
		req_size     = size;
		req_unsigned = uns;
		req_addr     = addr;
		req_wdata    = wdata;
		cnt = 0;
		while (!req_ready && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!req_ready)
			timed_out("req_ready");
		// taken on the rising edge in between
		@(negedge clk);
		req_valid = 1'b0;
		cnt = 0;
		while (!rsp_valid && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!rsp_valid)
			timed_out("rsp_valid");
		// random back-pressure
		hold = $urandom % 4;
		repeat (hold) @(negedge clk);
		rdata     = rsp_rdata;
		err       = rsp_err;
		rsp_ready = 1'b1;
		@(negedge clk);
		rsp_ready = 1'b0;
	endtask

	task automatic fetch_request(input logic [31:0] pc, output logic [31:0] word,
			output logic err);
		int cnt;
		int hold;
		@(negedge clk);
		fetch_valid = 1'b1;
		fetch_pc    = pc;
		cnt = 0;
		while (!fetch_ready && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!fetch_ready)
			timed_out("fetch_ready");
		@(negedge clk);
		fetch_valid = 1'b0;
		cnt = 0;
		while (!inst_valid && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!inst_valid)
			timed_out("inst_valid");
		hold = $urandom % 4;
		repeat (hold) @(negedge clk);
		word       = inst;
		err        = inst_err;
		inst_ready = 1'b1;
		@(negedge clk);
		inst_ready = 1'b0;
	endtask

	// store that must succeed, model follows
	task automatic store_data(input logic [31:0] addr, input mem_size_e size,
			input logic [63:0] data);
		logic [63:0] d;
		logic        e;
		lsu_request(1'b1, size, 1'b0, addr, data, d, e);
		check_val("rsp_err", 0, e);
		check_val("rsp_rdata", 0, d);
		store_model(addr, size, data);
	endtask

	task automatic check_load(input logic [31:0] addr, input mem_size_e size, input logic uns);
		logic [63:0] d;
		logic        e;
		lsu_request(1'b0, size, uns, addr, '0, d, e);
		check_val("rsp_rdata", load_model(addr, size, uns), d);
		check_val("rsp_err", 0, e);
	endtask

	task automatic check_fetch(input logic [31:0] pc);
		logic [31:0] w;
		logic        e;
		fetch_request(pc, w, e);
		check_val("inst", inst_model(pc), w);
		check_val("inst_err", 0, e);
	endtask

	// ****************************************
	// test sequence
	// ****************************************
	initial begin
		logic [31:0] a;
		logic [31:0] miss [3];
		logic [31:0] w;
		logic [63:0] d;
		logic        e;
		mem_size_e   sz;
		int          mark;

		void'($urandom(32'hca93));
		err_cnt      = 0;
		n_tests      = 0;
		n_failed     = 0;
		rst          = 1'b1;
		fetch_valid  = 1'b0;
		fetch_pc     = '0;
		inst_ready   = 1'b0;
		req_valid    = 1'b0;
		req_write    = 1'b0;
		req_size     = SIZE_B;
		req_unsigned = 1'b0;
		req_addr     = '0;
		req_wdata    = '0;
		rsp_ready    = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// idle outputs right after reset
		mark = err_cnt;
		check_val("inst_valid", 0, inst_valid);
		check_val("rsp_valid", 0, rsp_valid);
		check_val("fetch_ready", 1, fetch_ready);
		check_val("req_ready", 1, req_ready);
		close_test("reset state", mark);

		// whole array first, so every later load has known contents
		mark = err_cnt;
		for (int i = 0; i < SRAM_WORDS; i++) begin
			a = SRAM_BASE + 32'(8 * i);
			store_data(a, SIZE_D, {a ^ 32'h5a5a_a5a5, ~a});
		end
		for (int i = 0; i < 40; i++) begin
			sz = mem_size_e'($urandom % 4);
			a = rand_addr(sz);
			store_data(a, sz, {$urandom, $urandom});
			// every load size over the stored bytes
			for (int s = 0; s < 4; s++) begin
				check_load(a & ~((32'd1 << s) - 1), mem_size_e'(s), 1'b0);
				check_load(a & ~((32'd1 << s) - 1), mem_size_e'(s), 1'b1);
			end
		end
		close_test("stores and loads", mark);

		// both halves of a freshly written beat
		mark = err_cnt;
		for (int i = 0; i < 16; i++) begin
			a = rand_addr(SIZE_D);
			store_data(a, SIZE_D, {$urandom, $urandom});
			check_fetch(a);
			check_fetch(a + 4);
		end
		close_test("instruction fetch", mark);

		// both ports racing for the arbiter
		mark = err_cnt;
		fork
			for (int i = 0; i < 40; i++)
				check_fetch(rand_addr(SIZE_W));
			for (int i = 0; i < 40; i++) begin
				sz = mem_size_e'($urandom % 4);
				check_load(rand_addr(sz), sz, 1'($urandom % 2));
			end
		join
		close_test("concurrent fetch and load", mark);

		// outside the sram window
		mark = err_cnt;
		miss[0] = 32'h0000_1000;
		miss[1] = SRAM_BASE + SRAM_BYTES;
		miss[2] = 32'h7fff_fff8;
		for (int i = 0; i < 3; i++) begin
			lsu_request(1'b0, SIZE_D, 1'b0, miss[i], '0, d, e);
			check_val("rsp_err", 1, e);
			check_val("rsp_rdata", 0, d);
			lsu_request(1'b1, SIZE_D, 1'b0, miss[i], {$urandom, $urandom}, d, e);
			check_val("rsp_err", 1, e);
			fetch_request(miss[i], w, e);
			check_val("inst_err", 1, e);
			check_val("inst", 0, w);
			// sram word with the same low index bits
			check_load(SRAM_BASE | (miss[i] & 32'h0000_07f8), SIZE_D, 1'b0);
		end
		close_test("address miss", mark);

		// offset 1 up to size-1, model left alone
		mark = err_cnt;
		for (int i = 0; i < 12; i++) begin
			sz = mem_size_e'(1 + $urandom % 3);
			a = rand_addr(sz) + 1 + $urandom % ((1 << int'(sz)) - 1);
			lsu_request(1'b1, sz, 1'b0, a, {$urandom, $urandom}, d, e);
			check_val("rsp_err", 1, e);
			lsu_request(1'b0, sz, 1'($urandom % 2), a, '0, d, e);
			check_val("rsp_err", 1, e);
			check_val("rsp_rdata", 0, d);
			check_load(a & ~32'h7, SIZE_D, 1'b0);
		end
		close_test("misaligned access", mark);

		$display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, err_cnt);
		if (err_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/npc_mem_top.sv
`default_nettype none
`timescale 1ns/1ps

module npc_mem_top import npc_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	// fetch client
	input  logic              fetch_valid,
	output logic              fetch_ready,
	input  logic [ADDR_W-1:0] fetch_pc,
	output logic              inst_valid,
	input  logic              inst_ready,
	output logic [INST_W-1:0] inst,
	output logic              inst_err,
	// load/store client
	input  logic              req_valid,
	output logic              req_ready,
	input  logic              req_write,
	input  mem_size_e         req_size,
	input  logic              req_unsigned,
	input  logic [ADDR_W-1:0] req_addr,
	input  logic [DATA_W-1:0] req_wdata,
	output logic              rsp_valid,
	input  logic              rsp_ready,
	output logic [DATA_W-1:0] rsp_rdata,
	output logic              rsp_err
);

	// ****************************************
	// internal buses
	// ****************************************
	axi_bus_if fetch_bus ();
	axi_bus_if lsu_bus ();
	axi_bus_if mem_bus ();

	ifu_fetch fetch_i (
		.clk         (clk),
		.rst         (rst),
		.fetch_valid (fetch_valid),
		.fetch_ready (fetch_ready),
		.fetch_pc    (fetch_pc),
		.inst_valid  (inst_valid),
		.inst_ready  (inst_ready),
		.inst        (inst),
		.inst_err    (inst_err),
		.bus         (fetch_bus.master)
	);

	lsu_access lsu_i (
		.clk          (clk),
		.rst          (rst),
		.req_valid    (req_valid),
		.req_ready    (req_ready),
		.req_write    (req_write),
		.req_size     (req_size),
		.req_unsigned (req_unsigned),
		.req_addr     (req_addr),
		.req_wdata    (req_wdata),
		.rsp_valid    (rsp_valid),
		.rsp_ready    (rsp_ready),
		.rsp_rdata    (rsp_rdata),
		.rsp_err      (rsp_err),
		.bus          (lsu_bus.master)
	);

	// two masters onto the single sram port
	axi_arbiter arb_i (
		.clk       (clk),
		.rst       (rst),
		.fetch_bus (fetch_bus.slave),
		.lsu_bus   (lsu_bus.slave),
		.mem_bus   (mem_bus.master)
	);

	axi_sram sram_i (
		.clk (clk),
		.rst (rst),
		.bus (mem_bus.slave)
	);

endmodule

`default_nettype wire

// File: src/axi_sram.sv
`default_nettype none
`timescale 1ns/1ps

module axi_sram import npc_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	axi_bus_if.slave bus
);

	logic [DATA_W-1:0]     mem [SRAM_WORDS];
	logic                  rvalid_q;
	logic [DATA_W-1:0]     rdata_q;
	resp_e                 rresp_q;
	logic                  bvalid_q;
	resp_e                 bresp_q;
	logic                  ar_fire;
	logic                  wr_go;
	logic                  rd_hit;
	logic                  wr_hit;
	logic [SRAM_IDX_W-1:0] rd_idx;
	logic [SRAM_IDX_W-1:0] wr_idx;

	// address decode, anything outside the window misses
	assign rd_hit = (bus.araddr >= SRAM_BASE) && (bus.araddr - SRAM_BASE < SRAM_BYTES);
	assign wr_hit = (bus.awaddr >= SRAM_BASE) && (bus.awaddr - SRAM_BASE < SRAM_BYTES);
	assign rd_idx = bus.araddr[3 +: SRAM_IDX_W];
	assign wr_idx = bus.awaddr[3 +: SRAM_IDX_W];

	// ****************************************
	// read channel
	// ****************************************
	// one outstanding read at a time
	assign bus.arready = !rvalid_q;
	assign bus.rvalid  = rvalid_q;
	assign bus.rdata   = rdata_q;
	assign bus.rresp   = rresp_q;
	assign ar_fire     = bus.arvalid && bus.arready;

	// ****************************************
	// write channel
	// ****************************************
	// take aw and w only as a pair
	assign wr_go       = bus.awvalid && bus.wvalid && !bvalid_q;
	assign bus.awready = wr_go;
	assign bus.wready  = wr_go;
	assign bus.bvalid  = bvalid_q;
	assign bus.bresp   = bresp_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			if (ar_fire)
				rvalid_q <= 1'b1;
			else if (bus.rready)
				rvalid_q <= 1'b0;
			if (wr_go)
				bvalid_q <= 1'b1;
			else if (bus.bready)
				bvalid_q <= 1'b0;
		end
	end

	// array and response payload
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rdata_q <= rd_hit ? mem[rd_idx] : '0;
			rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
		end
		if (wr_go) begin
			bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
			// byte lanes by strobe, misses leave the array alone
			for (int i = 0; i < STRB_W; i++) begin
				if (wr_hit && bus.wstrb[i])
					mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
			end
		end
	end

endmodule

`default_nettype wire

// File: src/axi_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module axi_arbiter import npc_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	axi_bus_if.slave  fetch_bus,
	axi_bus_if.slave  lsu_bus,
	axi_bus_if.master mem_bus
);

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_FETCH,
		ARB_LSU
	} arb_state_e;

	arb_state_e state;
	// set when lsu won the previous grant
	logic       last_lsu;
	logic       sel_fetch;
	logic       sel_lsu;
	logic       ar_fire;
	logic       r_fire;

	// ****************************************
	// read grant
	// ****************************************
	// fetch wins unless lsu also asks and fetch went last
	assign sel_fetch = fetch_bus.arvalid && (!lsu_bus.arvalid || last_lsu);
	assign sel_lsu   = lsu_bus.arvalid && !sel_fetch;

	assign ar_fire = mem_bus.arvalid && mem_bus.arready;
	assign r_fire  = mem_bus.rvalid && mem_bus.rready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= ARB_IDLE;
			last_lsu <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (ar_fire) begin
						state    <= sel_lsu ? ARB_LSU : ARB_FETCH;
						last_lsu <= sel_lsu;
					end
				end
				// hold owner until its data beat completes
				ARB_FETCH, ARB_LSU: begin
					if (r_fire)
						state <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// address mux, only open in the idle cycle
	assign mem_bus.araddr  = sel_lsu ? lsu_bus.araddr : fetch_bus.araddr;
	assign mem_bus.arvalid = (state == ARB_IDLE) && (sel_fetch || sel_lsu);
	assign fetch_bus.arready = (state == ARB_IDLE) && sel_fetch && mem_bus.arready;
	assign lsu_bus.arready   = (state == ARB_IDLE) && sel_lsu && mem_bus.arready;

	// read data shared, valid only to the owner
	assign fetch_bus.rdata  = mem_bus.rdata;
	assign fetch_bus.rresp  = mem_bus.rresp;
	assign fetch_bus.rvalid = (state == ARB_FETCH) && mem_bus.rvalid;
	assign lsu_bus.rdata    = mem_bus.rdata;
	assign lsu_bus.rresp    = mem_bus.rresp;
	assign lsu_bus.rvalid   = (state == ARB_LSU) && mem_bus.rvalid;

	always_comb begin
		case (state)
			ARB_FETCH: mem_bus.rready = fetch_bus.rready;
			ARB_LSU:   mem_bus.rready = lsu_bus.rready;
			default:   mem_bus.rready = 1'b0;
		endcase
	end

	// ****************************************
	// write side, lsu only
	// ****************************************
	assign mem_bus.awaddr  = lsu_bus.awaddr;
	assign mem_bus.awvalid = lsu_bus.awvalid;
	assign mem_bus.wdata   = lsu_bus.wdata;
	assign mem_bus.wstrb   = lsu_bus.wstrb;
	assign mem_bus.wvalid  = lsu_bus.wvalid;
	assign mem_bus.bready  = lsu_bus.bready;
	assign lsu_bus.awready = mem_bus.awready;
	assign lsu_bus.wready  = mem_bus.wready;
	assign lsu_bus.bresp   = mem_bus.bresp;
	assign lsu_bus.bvalid  = mem_bus.bvalid;

	// fetch write channels parked
	assign fetch_bus.awready = 1'b0;
	assign fetch_bus.wready  = 1'b0;
	assign fetch_bus.bresp   = RESP_OKAY;
	assign fetch_bus.bvalid  = 1'b0;

endmodule

`default_nettype wire

// File: src/lsu_access.sv
`default_nettype none
`timescale 1ns/1ps

module lsu_access import npc_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              req_valid,
	output logic              req_ready,
	input  logic              req_write,
	input  mem_size_e         req_size,
	input  logic              req_unsigned,
	input  logic [ADDR_W-1:0] req_addr,
	input  logic [DATA_W-1:0] req_wdata,
	output logic              rsp_valid,
	input  logic              rsp_ready,
	output logic [DATA_W-1:0] rsp_rdata,
	output logic              rsp_err,
	axi_bus_if.master         bus
);

	typedef enum logic [1:0] {
		LSU_IDLE,
		LSU_READ,
		LSU_WRITE,
		LSU_RESP
	} lsu_state_e;

	lsu_state_e        state;
	logic              arvalid_q;
	logic              awvalid_q;
	logic              wvalid_q;
	logic [ADDR_W-1:0] addr_q;
	mem_size_e         size_q;
	logic              unsigned_q;
	logic [DATA_W-1:0] wdata_q;
	logic [STRB_W-1:0] wstrb_q;
	logic [DATA_W-1:0] rdata_q;
	logic              err_q;
	logic              req_fire;
	logic              misaligned;
	logic [DATA_W-1:0] wdata_rep;
	logic [STRB_W-1:0] strb_mask;
	logic [DATA_W-1:0] load_lane;
	logic [DATA_W-1:0] load_ext;

	assign req_ready = (state == LSU_IDLE);
	assign req_fire  = req_valid && req_ready;
	assign rsp_valid = (state == LSU_RESP);
	assign rsp_rdata = rdata_q;
	assign rsp_err   = err_q;

	// bus side, addresses go out beat aligned
	assign bus.araddr  = {addr_q[ADDR_W-1:3], 3'b000};
	assign bus.arvalid = arvalid_q;
	assign bus.rready  = (state == LSU_READ);
	assign bus.awaddr  = {addr_q[ADDR_W-1:3], 3'b000};
	assign bus.awvalid = awvalid_q;
	assign bus.wdata   = wdata_q;
	assign bus.wstrb   = wstrb_q;
	assign bus.wvalid  = wvalid_q;
	assign bus.bready  = (state == LSU_WRITE);

	// ****************************************
	// request decode
	// ****************************************
	always_comb begin
		case (req_size)
			SIZE_B: begin
				misaligned = 1'b0;
				strb_mask  = 8'h01;
				wdata_rep  = {8{req_wdata[7:0]}};
			end
			SIZE_H: begin
				misaligned = req_addr[0];
				strb_mask  = 8'h03;
				wdata_rep  = {4{req_wdata[15:0]}};
			end
			SIZE_W: begin
				misaligned = |req_addr[1:0];
				strb_mask  = 8'h0f;
				wdata_rep  = {2{req_wdata[31:0]}};
			end
			default: begin
				misaligned = |req_addr[2:0];
				strb_mask  = 8'hff;
				wdata_rep  = req_wdata;
			end
		endcase
	end

	// load path, shift addressed lanes to the bottom then extend
	assign load_lane = bus.rdata >> {addr_q[2:0], 3'b000};

	always_comb begin
		case (size_q)
			SIZE_B:  load_ext = {{(DATA_W-8){~unsigned_q & load_lane[7]}}, load_lane[7:0]};
			SIZE_H:  load_ext = {{(DATA_W-16){~unsigned_q & load_lane[15]}}, load_lane[15:0]};
			SIZE_W:  load_ext = {{(DATA_W-32){~unsigned_q & load_lane[31]}}, load_lane[31:0]};
			default: load_ext = load_lane;
		endcase
	end

	// ****************************************
	// control
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= LSU_IDLE;
			arvalid_q <= 1'b0;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
		end else begin
			case (state)
				LSU_IDLE: begin
					if (req_fire) begin
						// misaligned goes straight to the response
						if (misaligned) begin
							state <= LSU_RESP;
						end else if (req_write) begin
							state     <= LSU_WRITE;
							awvalid_q <= 1'b1;
							wvalid_q  <= 1'b1;
						end else begin
							state     <= LSU_READ;
							arvalid_q <= 1'b1;
						end
					end
				end
				LSU_READ: begin
					if (bus.arvalid && bus.arready)
						arvalid_q <= 1'b0;
					if (bus.rvalid && bus.rready)
						state <= LSU_RESP;
				end
				LSU_WRITE: begin
					// aw and w may be taken in different cycles
					if (bus.awvalid && bus.awready)
						awvalid_q <= 1'b0;
					if (bus.wvalid && bus.wready)
						wvalid_q <= 1'b0;
					if (bus.bvalid && bus.bready)
						state <= LSU_RESP;
				end
				LSU_RESP: begin
					if (rsp_ready)
						state <= LSU_IDLE;
				end
				default: state <= LSU_IDLE;
			endcase
		end
	end

	// request payload and response data
	always_ff @(posedge clk) begin
		if (req_fire) begin
			addr_q     <= req_addr;
			size_q     <= req_size;
			unsigned_q <= req_unsigned;
			wdata_q    <= wdata_rep;
			wstrb_q    <= strb_mask << req_addr[2:0];
			rdata_q    <= '0;
			err_q      <= misaligned;
		end
		if (bus.rvalid && bus.rready) begin
			rdata_q <= load_ext;
			err_q   <= (bus.rresp == RESP_SLVERR);
		end
		// stores return zero data
		if (bus.bvalid && bus.bready) begin
			rdata_q <= '0;
			err_q   <= (bus.bresp == RESP_SLVERR);
		end
	end

endmodule

`default_nettype wire

// File: src/ifu_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module ifu_fetch import npc_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              fetch_valid,
	output logic              fetch_ready,
	input  logic [ADDR_W-1:0] fetch_pc,
	output logic              inst_valid,
	input  logic              inst_ready,
	output logic [INST_W-1:0] inst,
	output logic              inst_err,
	axi_bus_if.master         bus
);

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_ADDR,
		FETCH_RESP
	} fetch_state_e;

	fetch_state_e      state;
	logic              arvalid_q;
	logic [ADDR_W-1:0] pc_q;
	logic [INST_W-1:0] inst_q;
	logic              err_q;
	logic              fetch_fire;
	logic              r_fire;

	assign fetch_ready = (state == FETCH_IDLE);
	assign fetch_fire  = fetch_valid && fetch_ready;
	assign r_fire      = bus.rvalid && bus.rready;

	// read channel, always a full aligned beat
	assign bus.araddr  = {pc_q[ADDR_W-1:3], 3'b000};
	assign bus.arvalid = arvalid_q;
	// rvalid cannot come before the ar transfer, so ready for the whole phase
	assign bus.rready  = (state == FETCH_ADDR);

	// fetch side never writes
	assign bus.awaddr  = '0;
	assign bus.awvalid = 1'b0;
	assign bus.wdata   = '0;
	assign bus.wstrb   = '0;
	assign bus.wvalid  = 1'b0;
	assign bus.bready  = 1'b0;

	assign inst_valid = (state == FETCH_RESP);
	assign inst       = inst_q;
	assign inst_err   = err_q;

	// ****************************************
	// control
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= FETCH_IDLE;
			arvalid_q <= 1'b0;
		end else begin
			case (state)
				FETCH_IDLE: begin
					if (fetch_fire) begin
						state     <= FETCH_ADDR;
						arvalid_q <= 1'b1;
					end
				end
				FETCH_ADDR: begin
					// drop arvalid once the address is taken
					if (bus.arvalid && bus.arready)
						arvalid_q <= 1'b0;
					if (r_fire)
						state <= FETCH_RESP;
				end
				FETCH_RESP: begin
					if (inst_ready)
						state <= FETCH_IDLE;
				end
				default: state <= FETCH_IDLE;
			endcase
		end
	end

	// pc and returned instruction
	always_ff @(posedge clk) begin
		if (fetch_fire)
			pc_q <= fetch_pc;
		if (r_fire) begin
			// bit 2 picks the upper word of the beat
			inst_q <= pc_q[2] ? bus.rdata[DATA_W-1:INST_W] : bus.rdata[INST_W-1:0];
			err_q  <= (bus.rresp == RESP_SLVERR);
		end
	end

endmodule

`default_nettype wire

// File: src/axi_bus_if.sv
`default_nettype none
`timescale 1ns/1ps

interface axi_bus_if import npc_pkg::*; ();

	// read address
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;

	// read data, single beat
	logic [DATA_W-1:0] rdata;
	resp_e             rresp;
	logic              rvalid;
	logic              rready;

	// write address
	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;

	// write data
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic              wvalid;
	logic              wready;

	// write response
	resp_e             bresp;
	logic              bvalid;
	logic              bready;

	modport master (
		output araddr, arvalid, rready,
		output awaddr, awvalid, wdata, wstrb, wvalid, bready,
		input  arready, rdata, rresp, rvalid,
		input  awready, wready, bresp, bvalid
	);

	modport slave (
		input  araddr, arvalid, rready,
		input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
		output arready, rdata, rresp, rvalid,
		output awready, wready, bresp, bvalid
	);

endinterface

`default_nettype wire

// File: src/npc_pkg.sv
`default_nettype none

package npc_pkg;

	// ****************************************
	// bus geometry
	// ****************************************
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	// one strobe bit per byte lane
	localparam int STRB_W = DATA_W / 8;
	// rv instructions are 32 bits, two per beat
	localparam int INST_W = 32;

	// ****************************************
	// sram address map
	// ****************************************
	localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;
	// 256 beats of 8 bytes, 2 KiB
	localparam int SRAM_WORDS = 256;
	localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);
	localparam logic [ADDR_W-1:0] SRAM_BYTES = ADDR_W'(SRAM_WORDS * STRB_W);

	// response codes, axi encoding
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// access size, log2 of the byte count
	typedef enum logic [1:0] {
		SIZE_B = 2'd0,
		SIZE_H = 2'd1,
		SIZE_W = 2'd2,
		SIZE_D = 2'd3
	} mem_size_e;

endpackage

`default_nettype wire
